// File: src.f
+incdir+hdl
hdl/bf_pkg.sv
hdl/bf_mode_if.sv
hdl/bf_mode_ctrl.sv
hdl/bf_hash.sv
hdl/bf_bank.sv
hdl/bf_delay.sv
hdl/bf_filter.sv
hdl/bloom_fault_inj.sv
verif/bf_checker.sv
verif/tb_bloom_fault_inj.sv

// File: Bender.yml
package:
  name: bloom_fault_inj

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/bf_pkg.sv
      - hdl/bf_mode_if.sv
      - hdl/bf_mode_ctrl.sv
      - hdl/bf_hash.sv
      - hdl/bf_bank.sv
      - hdl/bf_delay.sv
      - hdl/bf_filter.sv
      - hdl/bloom_fault_inj.sv
      - target: simulation
        files:
          - verif/bf_checker.sv
          - verif/tb_bloom_fault_inj.sv

// File: verif/tb_bloom_fault_inj.sv
`timescale 1ns/1ps
`include "bf_defs.svh"

module tb_bloom_fault_inj;

    typedef struct packed {
        logic                ar_valid;
        logic [`BF_ID_W-1:0] ar_id;
        logic                ar_match;
        logic                ar_hit;
        logic                aw_valid;
        logic [`BF_ID_W-1:0] aw_id;
        logic                aw_hit;
    } req_t;

    logic                clk;
    logic                rst_n;
    bf_pkg::csr_word_t   csr_data;
    bf_pkg::key_t        ar_addr;
    bf_pkg::key_t        aw_addr;
    logic [`BF_ID_W-1:0] ar_id;
    logic [`BF_ID_W-1:0] aw_id;
    logic                ar_valid;
    logic                aw_valid;
    logic [`BF_ID_W-1:0] ar_id_out;
    logic [`BF_ID_W-1:0] aw_id_out;
    logic                ar_valid_out;
    logic                aw_valid_out;
    logic                ar_fault;
    logic                aw_fault;

    // reference model state
    logic [`BF_FILTER_SIZE-1:0] bank_m [bf_pkg::NUM_BANKS];
    bf_pkg::mode_t              mode_m;
    bf_pkg::csr_word_t          csr_m;
    bf_pkg::key_t               mask_m;
    bf_pkg::key_t               code_m;
    req_t                       stage1;
    req_t                       stage2;
    logic [1:0]                 exp_faults;
    bf_pkg::key_t               keys [$];

    bloom_fault_inj DUT (.*);

    bf_checker checks (
        .*,
        .exp_ar_id    (stage2.ar_id),
        .exp_aw_id    (stage2.aw_id),
        .exp_ar_valid (stage2.ar_valid),
        .exp_aw_valid (stage2.aw_valid),
        .exp_ar_fault (exp_faults[1]),
        .exp_aw_fault (exp_faults[0])
    );

    function automatic bf_pkg::key_t rand_key();
        return bf_pkg::key_t'($urandom);
    endfunction

    // indexes a0, b0, a1, b1 of one key
    function automatic bf_pkg::idx_set_t key_indexes(input bf_pkg::key_t key);
        logic [31:0]      k;
        logic [31:0]      ha;
        logic [31:0]      hb;
        bf_pkg::idx_set_t idx;
        k = 32'(key);
        for (int i = 0; i < `BF_NUM_ROWS; i++) begin
            ha = k ^ (k >> (13 - i));
            ha = ha ^ (ha >> (7 - i));
            hb = k ^ `BF_HASH_SEED ^ (k >> (11 - i));
            hb = hb ^ (hb >> (3 - i));
            idx[2*i]     = ha[bf_pkg::IDX_W-1:0];
            idx[2*i + 1] = hb[bf_pkg::IDX_W-1:0];
        end
        return idx;
    endfunction

    function automatic logic in_filter(input bf_pkg::key_t key);
        bf_pkg::idx_set_t idx;
        logic             hit;
        idx = key_indexes(key);
        hit = 1'b1;
        for (int b = 0; b < bf_pkg::NUM_BANKS; b++) begin
            hit = hit & bank_m[b][idx[b]];
        end
        return hit;
    endfunction

    // {ar, aw} flags for the mode at output time
    function automatic logic [1:0] expected_faults(input bf_pkg::mode_t mode, input req_t r);
        case (mode)
            bf_pkg::MODE_LOOKUP:   return {r.ar_valid & r.ar_hit, r.aw_valid & r.aw_hit};
            bf_pkg::MODE_MATCH:    return {r.ar_valid & r.ar_match, r.aw_valid & r.aw_hit};
            bf_pkg::MODE_FLAG_ALL: return {r.ar_valid, r.aw_valid};
            default:               return 2'b00;
        endcase
    endfunction

    assign exp_faults = expected_faults(mode_m, stage2);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin : reference_model
        bf_pkg::idx_set_t wr_idx;
        if (!rst_n) begin
            for (int b = 0; b < bf_pkg::NUM_BANKS; b++) begin
                bank_m[b] = '0;
            end
            mode_m = bf_pkg::MODE_IDLE;
            csr_m  = '0;
            mask_m = '0;
            code_m = '0;
            stage1 = '0;
            stage2 = '0;
        end else begin
            stage2 = stage1;
            // compare uses the mask and code held before this edge
            stage1.ar_match = (mode_m == bf_pkg::MODE_MATCH) &&
                              ((ar_addr & mask_m) == (code_m & mask_m));
            wr_idx = key_indexes(csr_m[33:7]);
            if (mode_m == bf_pkg::MODE_INSERT || mode_m == bf_pkg::MODE_ERASE) begin
                for (int b = 0; b < bf_pkg::NUM_BANKS; b++) begin
                    bank_m[b][wr_idx[b]] = (mode_m == bf_pkg::MODE_INSERT);
                end
            end
            // a lookup sampled on the write edge sees the write
            stage1.ar_valid = ar_valid;
            stage1.ar_id    = ar_id;
            stage1.ar_hit   = in_filter(ar_addr);
            stage1.aw_valid = aw_valid;
            stage1.aw_id    = aw_id;
            stage1.aw_hit   = in_filter(aw_addr);
            if (mode_m == bf_pkg::MODE_LOAD_CODE && csr_m[63:59] == `BF_SIG_HI &&
                csr_m[4:0] == `BF_SIG_LO) begin
                mask_m = csr_m[58:32];
                code_m = csr_m[31:5];
            end
            case (csr_m)
                `BF_CMD_IDLE:      mode_m = bf_pkg::MODE_IDLE;
                `BF_CMD_INSERT:    mode_m = bf_pkg::MODE_INSERT;
                `BF_CMD_LOOKUP:    mode_m = bf_pkg::MODE_LOOKUP;
                `BF_CMD_LOAD_CODE: mode_m = bf_pkg::MODE_LOAD_CODE;
                `BF_CMD_MATCH:     mode_m = bf_pkg::MODE_MATCH;
                `BF_CMD_ERASE:     mode_m = bf_pkg::MODE_ERASE;
                `BF_CMD_FLAG_ALL:  mode_m = bf_pkg::MODE_FLAG_ALL;
                default:           mode_m = mode_m;
            endcase
            csr_m = csr_data;
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic set_mode(input bf_pkg::csr_word_t cmd, input bf_pkg::mode_t target);
        int n;
        csr_data = cmd;
        step();
        csr_data = '0;
        n = 0;
        while (DUT.mode_bus.mode != target && n < 8) begin
            step();
            n++;
        end
        if (DUT.mode_bus.mode != target) begin
            abort_run($sformatf("timed out waiting for mode %s", target.name()));
        end else begin
            repeat (3) step();
        end
    endtask

    task automatic write_key(input bf_pkg::key_t key);
        csr_data = {30'b0, key, 7'b0};
        step();
    endtask

    task automatic send_request(input logic ar_v, input bf_pkg::key_t ar_a,
                                input logic aw_v, input bf_pkg::key_t aw_a);
        ar_valid = ar_v;
        ar_addr  = ar_a;
        ar_id    = 8'($urandom);
        aw_valid = aw_v;
        aw_addr  = aw_a;
        aw_id    = 8'($urandom);
        step();
    endtask

    // lets the last requests leave the pipeline
    task automatic drain();
        int n;
        ar_valid = 1'b0;
        aw_valid = 1'b0;
        n = 0;
        while ((ar_valid_out || aw_valid_out) && n < 8) begin
            step();
            n++;
        end
        if (ar_valid_out || aw_valid_out) begin
            abort_run("valid outputs stayed high after the requests ended");
        end else begin
            repeat (3) step();
        end
    endtask

    initial begin : stimulus
        bf_pkg::key_t mask;
        bf_pkg::key_t code;
        bf_pkg::key_t a;
        void'($urandom(32'ha5064939));
        rst_n    = 1'b0;
        csr_data = '0;
        ar_addr  = '0;
        aw_addr  = '0;
        ar_id    = '0;
        aw_id    = '0;
        ar_valid = 1'b0;
        aw_valid = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        checks.start_test("idle_passthrough");
        for (int i = 0; i < 8; i++) begin
            send_request(1'b1, rand_key(), i[0], rand_key());
        end
        drain();
        checks.end_test();

        checks.start_test("insert_lookup");
        set_mode(`BF_CMD_INSERT, bf_pkg::MODE_INSERT);
        for (int i = 0; i < 16; i++) begin
            keys.push_back(rand_key());
            write_key(keys[i]);
        end
        set_mode(`BF_CMD_LOOKUP, bf_pkg::MODE_LOOKUP);
        foreach (keys[i]) begin
            send_request(1'b1, keys[i], 1'b1, rand_key());
        end
        foreach (keys[i]) begin
            send_request(1'b1, rand_key(), 1'b1, keys[i]);
        end
        drain();
        checks.end_test();

        checks.start_test("erase_lookup");
        set_mode(`BF_CMD_ERASE, bf_pkg::MODE_ERASE);
        for (int i = 0; i < 6; i++) begin
            write_key(keys[i]);
        end
        set_mode(`BF_CMD_LOOKUP, bf_pkg::MODE_LOOKUP);
        foreach (keys[i]) begin
            send_request(1'b1, keys[i], 1'b1, keys[keys.size() - 1 - i]);
        end
        drain();
        checks.end_test();

        checks.start_test("code_match");
        mask = rand_key() | 27'h7F00000;
        code = rand_key();
        set_mode(`BF_CMD_LOAD_CODE, bf_pkg::MODE_LOAD_CODE);
        csr_data = {`BF_SIG_HI, mask, code, `BF_SIG_LO};
        step();
        // bad low signature that must not load
        csr_data = {`BF_SIG_HI, ~mask, ~code, 5'b10100};
        step();
        set_mode(`BF_CMD_MATCH, bf_pkg::MODE_MATCH);
        for (int i = 0; i < 16; i++) begin
            a = rand_key();
            if (i[0]) begin
                a = (a & ~mask) | (code & mask);
            end
            send_request(1'b1, a, 1'b1, keys[i]);
        end
        drain();
        checks.end_test();

        checks.start_test("flag_all");
        set_mode(`BF_CMD_FLAG_ALL, bf_pkg::MODE_FLAG_ALL);
        // not a command word
        csr_data = 64'h0123_4567_89ab_cdef;
        for (int i = 0; i < 12; i++) begin
            send_request(i[0], rand_key(), i[1], rand_key());
        end
        checks.check_value("mode", 64'(bf_pkg::MODE_FLAG_ALL), 64'(DUT.mode_bus.mode));
        csr_data = '0;
        drain();
        checks.end_test();

        $display("tests %0d, failed %0d, mismatches %0d",
                 checks.tests_run, checks.tests_failed, checks.total_errors);
        if (checks.tests_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verif/bf_checker.sv
`timescale 1ns/1ps
`include "bf_defs.svh"

module bf_checker (
    input logic                clk,
    input logic                rst_n,
    input logic [`BF_ID_W-1:0] ar_id_out,
    input logic [`BF_ID_W-1:0] aw_id_out,
    input logic                ar_valid_out,
    input logic                aw_valid_out,
    input logic                ar_fault,
    input logic                aw_fault,
    input logic [`BF_ID_W-1:0] exp_ar_id,
    input logic [`BF_ID_W-1:0] exp_aw_id,
    input logic                exp_ar_valid,
    input logic                exp_aw_valid,
    input logic                exp_ar_fault,
    input logic                exp_aw_fault
);

    string       test_name;
    string       first_what;
    logic [63:0] first_exp;
    logic [63:0] first_act;
    logic        active = 1'b0;
    int          cycles = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          total_errors = 0;

    task automatic start_test(input string name);
        test_name = name;
        cycles    = 0;
        errors    = 0;
        active    = 1'b1;
    endtask

    // first difference of a test is the one reported
    task automatic check_value(input string       what,
                               input logic [63:0] exp,
                               input logic [63:0] act);
        if (exp !== act) begin
            if (errors == 0) begin
                first_what = what;
                first_exp  = exp;
                first_act  = act;
            end
            errors++;
            total_errors++;
        end
    endtask

    task automatic end_test();
        active = 1'b0;
        tests_run++;
        if (errors == 0) begin
            $display("PASS %s, %0d cycles compared", test_name, cycles);
        end else begin
            tests_failed++;
            $display("MISMATCH %s %s expected %0h actual %0h, %0d mismatches",
                     test_name, first_what, first_exp, first_act, errors);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && active) begin
            cycles++;
            check_value("ar_id_out", 64'(exp_ar_id), 64'(ar_id_out));
            check_value("aw_id_out", 64'(exp_aw_id), 64'(aw_id_out));
            check_value("ar_valid_out", 64'(exp_ar_valid), 64'(ar_valid_out));
            check_value("aw_valid_out", 64'(exp_aw_valid), 64'(aw_valid_out));
            check_value("ar_fault", 64'(exp_ar_fault), 64'(ar_fault));
            check_value("aw_fault", 64'(exp_aw_fault), 64'(aw_fault));
        end
    end

endmodule

// File: hdl/bloom_fault_inj.sv
`timescale 1ns/1ps
`include "bf_defs.svh"

module bloom_fault_inj (
    input  logic                clk,
    input  logic                rst_n,
    input  bf_pkg::csr_word_t   csr_data,
    input  bf_pkg::key_t        ar_addr,
    input  bf_pkg::key_t        aw_addr,
    input  logic [`BF_ID_W-1:0] ar_id,
    input  logic [`BF_ID_W-1:0] aw_id,
    input  logic                ar_valid,
    input  logic                aw_valid,
    output logic [`BF_ID_W-1:0] ar_id_out,
    output logic [`BF_ID_W-1:0] aw_id_out,
    output logic                ar_valid_out,
    output logic                aw_valid_out,
    output logic                ar_fault,
    output logic                aw_fault
);

    bf_pkg::ar_payload_t ar_d;
    bf_pkg::ar_payload_t ar_q;
    bf_pkg::aw_payload_t aw_d;
    bf_pkg::aw_payload_t aw_q;
    logic                ar_present;
    logic                aw_present;
    logic                ar_match;

    bf_mode_if mode_bus ();

    bf_mode_ctrl u_ctrl (.clk(clk), .rst_n(rst_n), .csr_data(csr_data), .mode_bus(mode_bus));

    bf_filter u_filter (
        .clk(clk), .rst_n(rst_n), .mode_bus(mode_bus), .ar_addr(ar_addr), .aw_addr(aw_addr),
        .ar_present(ar_present), .aw_present(aw_present)
    );

    // masked compare that only holds in match mode
    assign ar_match = (mode_bus.mode == bf_pkg::MODE_MATCH) &&
                      ((ar_addr & mode_bus.mask) == (mode_bus.code & mode_bus.mask));

    assign ar_d = '{valid: ar_valid, id: ar_id, match: ar_match};
    assign aw_d = '{valid: aw_valid, id: aw_id};

    bf_delay #(.payload_t(bf_pkg::ar_payload_t)) u_ar_dly (
        .clk(clk), .rst_n(rst_n), .d(ar_d), .q(ar_q)
    );
    bf_delay #(.payload_t(bf_pkg::aw_payload_t)) u_aw_dly (
        .clk(clk), .rst_n(rst_n), .d(aw_d), .q(aw_q)
    );

    assign ar_id_out    = ar_q.id;
    assign aw_id_out    = aw_q.id;
    assign ar_valid_out = ar_q.valid;
    assign aw_valid_out = aw_q.valid;

    // decided with the mode at output time
    always_comb begin
        ar_fault = 1'b0;
        aw_fault = 1'b0;
        case (mode_bus.mode)
            bf_pkg::MODE_LOOKUP: begin
                ar_fault = ar_q.valid & ar_present;
                aw_fault = aw_q.valid & aw_present;
            end
            bf_pkg::MODE_MATCH: begin
                ar_fault = ar_q.valid & ar_q.match;
                aw_fault = aw_q.valid & aw_present;
            end
            bf_pkg::MODE_FLAG_ALL: begin
                ar_fault = ar_q.valid;
                aw_fault = aw_q.valid;
            end
            default: begin
                ar_fault = 1'b0;
                aw_fault = 1'b0;
            end
        endcase
    end

endmodule

// File: hdl/bf_filter.sv
`timescale 1ns/1ps

module bf_filter (
    input  logic         clk,
    input  logic         rst_n,
    bf_mode_if.filter    mode_bus,
    input  bf_pkg::key_t ar_addr,
    input  bf_pkg::key_t aw_addr,
    output logic         ar_present,
    output logic         aw_present
);

    bf_pkg::idx_set_t              ins_idx;
    bf_pkg::idx_set_t              ar_idx;
    bf_pkg::idx_set_t              aw_idx;
    bf_pkg::idx_set_t              rd1_sel;
    logic                          updating;
    logic                          wr_bit;
    logic [bf_pkg::NUM_BANKS-1:0]  rd1_bits;
    logic [bf_pkg::NUM_BANKS-1:0]  rd2_bits;

    bf_hash u_hash_ins (
        .key (mode_bus.key),
        .idx (ins_idx)
    );

    bf_hash u_hash_ar (
        .key (ar_addr),
        .idx (ar_idx)
    );

    bf_hash u_hash_aw (
        .key (aw_addr),
        .idx (aw_idx)
    );

    assign updating = (mode_bus.mode == bf_pkg::MODE_INSERT) ||
                      (mode_bus.mode == bf_pkg::MODE_ERASE);
    assign wr_bit   = (mode_bus.mode == bf_pkg::MODE_INSERT);

    // port 1 is shared between the insert key and read lookups
    assign rd1_sel = updating ? ins_idx : ar_idx;

    for (genvar b = 0; b < bf_pkg::NUM_BANKS; b++) begin : g_bank
        bf_bank u_bank (
            .clk     (clk),
            .rst_n   (rst_n),
            .wr_en   (updating),
            .wr_idx  (ins_idx[b]),
            .wr_bit  (wr_bit),
            .rd1_idx (rd1_sel[b]),
            .rd2_idx (aw_idx[b]),
            .rd1_bit (rd1_bits[b]),
            .rd2_bit (rd2_bits[b])
        );
    end

    // present only when every bank agrees
    assign ar_present = &rd1_bits;
    assign aw_present = &rd2_bits;

endmodule

// File: hdl/bf_delay.sv
`timescale 1ns/1ps

module bf_delay #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t d,
    output payload_t q
);

    payload_t stage1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage1 <= '0;
            q      <= '0;
        end else begin
            stage1 <= d;
            q      <= stage1;
        end
    end

endmodule

// File: hdl/bf_bank.sv
`timescale 1ns/1ps
`include "bf_defs.svh"

module bf_bank (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           wr_en,
    input  bf_pkg::index_t wr_idx,
    input  logic           wr_bit,
    input  bf_pkg::index_t rd1_idx,
    input  bf_pkg::index_t rd2_idx,
    output logic           rd1_bit,
    output logic           rd2_bit
);

    logic [`BF_FILTER_SIZE-1:0] mem;
    bf_pkg::index_t             rd1_q;
    bf_pkg::index_t             rd2_q;

    // address register then data register on both read ports
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem     <= '0;
            rd1_q   <= '0;
            rd2_q   <= '0;
            rd1_bit <= 1'b0;
            rd2_bit <= 1'b0;
        end else begin
            if (wr_en) begin
                mem[wr_idx] <= wr_bit;
            end
            rd1_q   <= rd1_idx;
            rd2_q   <= rd2_idx;
            rd1_bit <= mem[rd1_q];
            rd2_bit <= mem[rd2_q];
        end
    end

endmodule

// File: hdl/bf_hash.sv
`timescale 1ns/1ps
`include "bf_defs.svh"

module bf_hash (
    input  bf_pkg::key_t     key,
    output bf_pkg::idx_set_t idx
);

    logic [31:0] key_ext;

    assign key_ext = 32'(key);

    for (genvar i = 0; i < `BF_NUM_ROWS; i++) begin : g_row
        logic [31:0] ha1;
        logic [31:0] ha2;
        logic [31:0] hb1;
        logic [31:0] hb2;

        // family a with shifts that shrink by one per row
        assign ha1 = key_ext ^ (key_ext >> (13 - i));
        assign ha2 = ha1 ^ (ha1 >> (7 - i));

        // family b mixes in the seed
        assign hb1 = (key_ext ^ `BF_HASH_SEED) ^ (key_ext >> (11 - i));
        assign hb2 = hb1 ^ (hb1 >> (3 - i));

        assign idx[2*i]   = ha2[bf_pkg::IDX_W-1:0];
        assign idx[2*i+1] = hb2[bf_pkg::IDX_W-1:0];
    end

endmodule

// File: hdl/bf_mode_ctrl.sv
`timescale 1ns/1ps
`include "bf_defs.svh"

module bf_mode_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  bf_pkg::csr_word_t csr_data,
    bf_mode_if.ctrl           mode_bus
);

    bf_pkg::csr_word_t csr_q;
    bf_pkg::mode_t     mode_q;
    bf_pkg::mode_t     mode_next;
    bf_pkg::key_t      mask_q;
    bf_pkg::key_t      code_q;
    logic              load_ok;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            csr_q <= '0;
        end else begin
            csr_q <= csr_data;
        end
    end

    // unknown words keep the current mode
    always_comb begin
        case (csr_q)
            `BF_CMD_IDLE:      mode_next = bf_pkg::MODE_IDLE;
            `BF_CMD_INSERT:    mode_next = bf_pkg::MODE_INSERT;
            `BF_CMD_LOOKUP:    mode_next = bf_pkg::MODE_LOOKUP;
            `BF_CMD_LOAD_CODE: mode_next = bf_pkg::MODE_LOAD_CODE;
            `BF_CMD_MATCH:     mode_next = bf_pkg::MODE_MATCH;
            `BF_CMD_ERASE:     mode_next = bf_pkg::MODE_ERASE;
            `BF_CMD_FLAG_ALL:  mode_next = bf_pkg::MODE_FLAG_ALL;
            default:           mode_next = mode_q;
        endcase
    end

    assign load_ok = (mode_q == bf_pkg::MODE_LOAD_CODE) &&
                     (csr_q[63:59] == `BF_SIG_HI) &&
                     (csr_q[4:0] == `BF_SIG_LO);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mode_q <= bf_pkg::MODE_IDLE;
            mask_q <= '0;
            code_q <= '0;
        end else begin
            mode_q <= mode_next;
            if (load_ok) begin
                mask_q <= csr_q[58:32];
                code_q <= csr_q[31:5];
            end
        end
    end

    assign mode_bus.mode = mode_q;
    assign mode_bus.key  = csr_q[33:7];
    assign mode_bus.mask = mask_q;
    assign mode_bus.code = code_q;

endmodule

// File: hdl/bf_mode_if.sv
`timescale 1ns/1ps

interface bf_mode_if;

    bf_pkg::mode_t mode;
    // key field of the registered control word
    bf_pkg::key_t  key;
    bf_pkg::key_t  mask;
    bf_pkg::key_t  code;

    modport ctrl   (output mode, output key, output mask, output code);

    modport filter (input mode, input key);

    modport decide (input mode, input mask, input code);

endinterface

// File: hdl/bf_pkg.sv
`include "bf_defs.svh"

package bf_pkg;

    localparam int IDX_W     = $clog2(`BF_FILTER_SIZE);
    localparam int NUM_BANKS = 2 * `BF_NUM_ROWS;

    typedef enum logic [2:0] {
        MODE_IDLE,
        MODE_INSERT,
        MODE_ERASE,
        MODE_LOOKUP,
        MODE_LOAD_CODE,
        MODE_MATCH,
        MODE_FLAG_ALL
    } mode_t;

    typedef logic [`BF_KEY_W-1:0] key_t;
    typedef logic [IDX_W-1:0]     index_t;
    typedef logic [63:0]          csr_word_t;

    // bank order a0, b0, a1, b1
    typedef logic [0:NUM_BANKS-1][IDX_W-1:0] idx_set_t;

    typedef struct packed {
        logic                valid;
        logic [`BF_ID_W-1:0] id;
        logic                match;
    } ar_payload_t;

    typedef struct packed {
        logic                valid;
        logic [`BF_ID_W-1:0] id;
    } aw_payload_t;

endpackage

// File: hdl/bf_defs.svh
`ifndef BF_DEFS_SVH
`define BF_DEFS_SVH

// filter geometry
`define BF_FILTER_SIZE 8192
`define BF_NUM_ROWS    2

// request fields
`define BF_ID_W        8
`define BF_KEY_W       27

// command words seen on the control register
`define BF_CMD_IDLE      64'h7EA7BA0F2EA9BA08
`define BF_CMD_INSERT    64'hAFE0D0FDBF0FAFC0
`define BF_CMD_LOOKUP    64'hFEA0AFE0B0FFA0EF
`define BF_CMD_LOAD_CODE 64'hF0E0FEA0BACFEFAC
`define BF_CMD_MATCH     64'hCEAFE0AC0FEF0AE0
`define BF_CMD_ERASE     64'hAECF0EAFBEABBCBF
`define BF_CMD_FLAG_ALL  64'h3EA7BEA60EAFAEA8

// code load word carries these in bits 63:59 and 4:0
`define BF_SIG_HI 5'b01010
`define BF_SIG_LO 5'b10101

// xor constant of hash family b
`define BF_HASH_SEED 32'h811c9dc5

`endif
